// File: rtl/core_region.sv
// memory side of the core region: instruction RAM, data RAM and bus bridge
// loads/stores outside page 0x001 go to the master port; slave port loads both RAMs
`default_nettype none
`timescale 1ns/1ps

`include "core_region_params.svh"

module core_region (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  // instruction fetch
  input  wire logic                      instr_req_i,
  input  wire logic [`CR_ADDR_W-1:0]     instr_addr_i,
  output logic                           instr_gnt_o,
  output logic                           instr_rvalid_o,
  output logic      [`CR_DATA_W-1:0]     instr_rdata_o,
  // load/store
  input  wire logic                      lsu_req_i,
  input  wire core_region_pkg::mem_req_t lsu_req_data_i,
  output logic                           lsu_gnt_o,
  output logic                           lsu_rvalid_o,
  output logic      [`CR_DATA_W-1:0]     lsu_rdata_o,
  // external slave
  input  wire logic                      slv_valid_i,
  input  wire core_region_pkg::slv_req_t slv_req_i,
  output logic                           slv_ready_o,
  output logic                           slv_rsp_valid_o,
  output logic      [`CR_DATA_W-1:0]     slv_rsp_data_o,
  // external master
  output logic                           mst_req_valid_o,
  output core_region_pkg::mem_req_t      mst_req_o,
  input  wire logic                      mst_req_ready_i,
  input  wire logic                      mst_rsp_valid_i,
  input  wire logic [`CR_DATA_W-1:0]     mst_rsp_data_i,
  output logic                           mst_rsp_ready_o
);

  import core_region_pkg::*;

  mem_req_t              instr_req_data;
  logic                  slv_to_instr;
  logic                  imem_ext_req;
  logic                  imem_ext_gnt;
  logic                  imem_ext_rvalid;
  logic [`CR_DATA_W-1:0] imem_rdata;
  logic                  dmem_ext_req;
  logic                  dmem_ext_gnt;
  logic                  dmem_ext_rvalid;
  logic [`CR_DATA_W-1:0] dmem_rdata;
  logic                  dmem_core_req;
  logic                  dmem_core_gnt;
  logic                  dmem_core_rvalid;
  logic                  br_req;
  logic                  br_gnt;
  logic                  br_rvalid;
  logic [`CR_DATA_W-1:0] br_rdata;

  //////////////////////////////////////////////////////////////////////////////
  // slave port steering
  //////////////////////////////////////////////////////////////////////////////

  assign slv_to_instr = (slv_req_i.target == TGT_INSTR);
  assign imem_ext_req = slv_valid_i & slv_to_instr;
  assign dmem_ext_req = slv_valid_i & ~slv_to_instr;
  assign slv_ready_o  = slv_to_instr ? imem_ext_gnt : dmem_ext_gnt;

  // at most one slave response in flight per cycle
  assign slv_rsp_valid_o = imem_ext_rvalid | dmem_ext_rvalid;
  assign slv_rsp_data_o  = imem_ext_rvalid ? imem_rdata : dmem_rdata;

  // fetch is a full-word read
  assign instr_req_data.addr  = instr_addr_i;
  assign instr_req_data.we    = 1'b0;
  assign instr_req_data.be    = '1;
  assign instr_req_data.wdata = '0;
  assign instr_rdata_o        = imem_rdata;

  //////////////////////////////////////////////////////////////////////////////
  // memories and load/store path
  //////////////////////////////////////////////////////////////////////////////

  ram_mux #(.ADDR_W(`CR_IMEM_AW)) imem_mux (
    .clk (clk), .rst_n (rst_n),
    .ext_req_i (imem_ext_req), .ext_req_data_i (slv_req_i.req),
    .ext_gnt_o (imem_ext_gnt), .ext_rvalid_o (imem_ext_rvalid),
    .core_req_i (instr_req_i), .core_req_data_i (instr_req_data),
    .core_gnt_o (instr_gnt_o), .core_rvalid_o (instr_rvalid_o),
    .rdata_o (imem_rdata)
  );

  ram_mux #(.ADDR_W(`CR_DMEM_AW)) dmem_mux (
    .clk (clk), .rst_n (rst_n),
    .ext_req_i (dmem_ext_req), .ext_req_data_i (slv_req_i.req),
    .ext_gnt_o (dmem_ext_gnt), .ext_rvalid_o (dmem_ext_rvalid),
    .core_req_i (dmem_core_req), .core_req_data_i (lsu_req_data_i),
    .core_gnt_o (dmem_core_gnt), .core_rvalid_o (dmem_core_rvalid),
    .rdata_o (dmem_rdata)
  );

  lsu_demux lsu_demux_i (
    .clk (clk), .rst_n (rst_n),
    .lsu_req_i (lsu_req_i), .lsu_req_data_i (lsu_req_data_i),
    .lsu_gnt_o (lsu_gnt_o), .lsu_rvalid_o (lsu_rvalid_o), .lsu_rdata_o (lsu_rdata_o),
    .loc_req_o (dmem_core_req), .loc_gnt_i (dmem_core_gnt),
    .loc_rvalid_i (dmem_core_rvalid), .loc_rdata_i (dmem_rdata),
    .ext_req_o (br_req), .ext_gnt_i (br_gnt),
    .ext_rvalid_i (br_rvalid), .ext_rdata_i (br_rdata)
  );

  ext_bus_bridge ext_bus_bridge_i (
    .clk (clk), .rst_n (rst_n),
    .req_i (br_req), .req_data_i (lsu_req_data_i),
    .gnt_o (br_gnt), .rvalid_o (br_rvalid), .rdata_o (br_rdata),
    .mst_req_valid_o (mst_req_valid_o), .mst_req_o (mst_req_o),
    .mst_req_ready_i (mst_req_ready_i),
    .mst_rsp_valid_i (mst_rsp_valid_i), .mst_rsp_data_i (mst_rsp_data_i),
    .mst_rsp_ready_o (mst_rsp_ready_o)
  );

endmodule

`default_nettype wire

// File: rtl/core_region_params.svh
// widths, memory depths and address map of the core region
// memory depths are word-address widths; byte address bits 1:0 are ignored
`ifndef CORE_REGION_PARAMS_SVH
`define CORE_REGION_PARAMS_SVH

// bus widths
`define CR_ADDR_W 32
`define CR_DATA_W 32
`define CR_BE_W   4

// local RAM sizes in word-address bits
`define CR_IMEM_AW 10
`define CR_DMEM_AW 10

// load/store page decode
// page field is addr[31:20], local data page is 0x001
`define CR_PAGE_LSB   20
`define CR_LOCAL_PAGE 12'h001

`endif

// File: rtl/core_region_pkg.sv
// request types and state encodings shared by the core region RTL
// widths follow core_region_params.svh
`default_nettype none

`include "core_region_params.svh"

package core_region_pkg;

  // core-style request fields, 69 bits
  typedef struct packed {
    logic [`CR_ADDR_W-1:0] addr;
    logic                  we;
    logic [`CR_BE_W-1:0]   be;
    logic [`CR_DATA_W-1:0] wdata;
  } mem_req_t;

  // which local RAM an external slave request goes to
  typedef enum logic {
    TGT_INSTR = 1'b0,
    TGT_DATA  = 1'b1
  } target_e;

  // external slave request, 70 bits
  typedef struct packed {
    target_e  target;
    mem_req_t req;
  } slv_req_t;

  // origin of the next load/store response
  typedef enum logic {
    RESP_RAM = 1'b0,
    RESP_EXT = 1'b1
  } resp_src_e;

  // bus bridge FSM
  typedef enum logic {
    BR_IDLE = 1'b0,
    BR_WAIT = 1'b1
  } bridge_state_e;

endpackage

`default_nettype wire

// File: rtl/ext_bus_bridge.sv
// core-style requests to a valid/ready request and response pair
// one request outstanding at a time; mst_req_o is held by the requester until granted
`default_nettype none
`timescale 1ns/1ps

`include "core_region_params.svh"

module ext_bus_bridge (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      req_i,
  input  wire core_region_pkg::mem_req_t req_data_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic      [`CR_DATA_W-1:0]     rdata_o,
  output logic                           mst_req_valid_o,
  output core_region_pkg::mem_req_t      mst_req_o,
  input  wire logic                      mst_req_ready_i,
  input  wire logic                      mst_rsp_valid_i,
  input  wire logic [`CR_DATA_W-1:0]     mst_rsp_data_i,
  output logic                           mst_rsp_ready_o
);

  import core_region_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;

  // request side, only offered while nothing is outstanding
  assign mst_req_valid_o = req_i & (state_q == BR_IDLE);
  assign mst_req_o       = req_data_i;
  assign gnt_o           = mst_req_valid_o & mst_req_ready_i;

  // response side
  assign mst_rsp_ready_o = (state_q == BR_WAIT);
  assign rvalid_o        = mst_rsp_valid_i & mst_rsp_ready_o;
  assign rdata_o         = mst_rsp_data_i;

  //////////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      BR_IDLE:
      begin
        if (gnt_o)
          state_d = BR_WAIT;
      end
      BR_WAIT:
      begin
        // back to idle once the response is taken
        if (rvalid_o)
          state_d = BR_IDLE;
      end
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= BR_IDLE;
    else
      state_q <= state_d;
  end

  // the outside only answers a request that was actually sent
  a_no_stray_rsp : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == BR_IDLE) |-> !mst_rsp_valid_i);

endmodule

`default_nettype wire

// File: rtl/lsu_demux.sv
// splits load/store requests between the local data page and the bus bridge
// response source is tracked per accepted request; no latency added
`default_nettype none
`timescale 1ns/1ps

`include "core_region_params.svh"

module lsu_demux (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      lsu_req_i,
  input  wire core_region_pkg::mem_req_t lsu_req_data_i,
  output logic                           lsu_gnt_o,
  output logic                           lsu_rvalid_o,
  output logic      [`CR_DATA_W-1:0]     lsu_rdata_o,
  output logic                           loc_req_o,
  input  wire logic                      loc_gnt_i,
  input  wire logic                      loc_rvalid_i,
  input  wire logic [`CR_DATA_W-1:0]     loc_rdata_i,
  output logic                           ext_req_o,
  input  wire logic                      ext_gnt_i,
  input  wire logic                      ext_rvalid_i,
  input  wire logic [`CR_DATA_W-1:0]     ext_rdata_i
);

  import core_region_pkg::*;

  logic      is_local;
  resp_src_e src_q;

  // page decode on addr[31:20]
  assign is_local  = (lsu_req_data_i.addr[`CR_ADDR_W-1:`CR_PAGE_LSB] == `CR_LOCAL_PAGE);
  assign loc_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;
  assign lsu_gnt_o = (loc_req_o & loc_gnt_i) | (ext_req_o & ext_gnt_i);

  // remember where the accepted request went
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      src_q <= RESP_RAM;
    else if (lsu_gnt_o)
      src_q <= is_local ? RESP_RAM : RESP_EXT;
  end

  //////////////////////////////////////////////////////////////////////////////
  // response routing
  //////////////////////////////////////////////////////////////////////////////

  assign lsu_rvalid_o = loc_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (src_q == RESP_EXT) ? ext_rdata_i : loc_rdata_i;

  // the two sides never answer in the same cycle
  a_one_rsp : assert property (@(posedge clk) disable iff (!rst_n)
    !(loc_rvalid_i && ext_rvalid_i));

endmodule

`default_nettype wire

// File: rtl/ram_mux.sv
// two-port arbiter in front of one sp_ram, round-robin on conflict
// rvalid follows the grant by exactly one cycle; rdata_o is shared by both ports
`default_nettype none
`timescale 1ns/1ps

`include "core_region_params.svh"

module ram_mux #(
  parameter int ADDR_W = 10
) (
  input  wire logic                     clk,
  input  wire logic                     rst_n,
  input  wire logic                     ext_req_i,
  input  wire core_region_pkg::mem_req_t ext_req_data_i,
  output logic                          ext_gnt_o,
  output logic                          ext_rvalid_o,
  input  wire logic                     core_req_i,
  input  wire core_region_pkg::mem_req_t core_req_data_i,
  output logic                          core_gnt_o,
  output logic                          core_rvalid_o,
  output logic      [`CR_DATA_W-1:0]    rdata_o
);

  import core_region_pkg::*;

  mem_req_t sel_req;
  logic     ram_en;
  // winner of the latest grant, also tells who owns the pending response
  logic     last_ext_q;
  logic     rsp_valid_q;

  //////////////////////////////////////////////////////////////////////////////
  // arbitration
  //////////////////////////////////////////////////////////////////////////////

  // on conflict the port that did not win last time goes first
  assign ext_gnt_o  = ext_req_i & (~core_req_i | ~last_ext_q);
  assign core_gnt_o = core_req_i & (~ext_req_i | last_ext_q);
  assign ram_en     = ext_gnt_o | core_gnt_o;
  assign sel_req    = ext_gnt_o ? ext_req_data_i : core_req_data_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      last_ext_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      rsp_valid_q <= ram_en;
      if (ram_en)
        last_ext_q <= ext_gnt_o;
    end
  end

  assign ext_rvalid_o  = rsp_valid_q & last_ext_q;
  assign core_rvalid_o = rsp_valid_q & ~last_ext_q;

  sp_ram #(
    .ADDR_W (ADDR_W)
  ) ram_i (
    .clk     (clk),
    .en_i    (ram_en),
    .we_i    (sel_req.we),
    .be_i    (sel_req.be),
    .addr_i  (sel_req.addr[ADDR_W+1:2]),
    .wdata_i (sel_req.wdata),
    .rdata_o (rdata_o)
  );

  // one grant per cycle
  a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
    !(ext_gnt_o && core_gnt_o));

  // every response pulse is owed to a grant one cycle back
  a_ext_rsp : assert property (@(posedge clk) disable iff (!rst_n)
    ext_rvalid_o |-> $past(ext_gnt_o));
  a_core_rsp : assert property (@(posedge clk) disable iff (!rst_n)
    core_rvalid_o |-> $past(core_gnt_o));

endmodule

`default_nettype wire

// File: rtl/sp_ram.sv
// single-port word RAM, read data registered one cycle after en_i
// a write returns the old word on rdata_o; contents are undefined after power-up
`default_nettype none
`timescale 1ns/1ps

`include "core_region_params.svh"

module sp_ram #(
  parameter int ADDR_W = 10
) (
  input  wire logic                  clk,
  input  wire logic                  en_i,
  input  wire logic                  we_i,
  input  wire logic [`CR_BE_W-1:0]   be_i,
  input  wire logic [ADDR_W-1:0]     addr_i,
  input  wire logic [`CR_DATA_W-1:0] wdata_i,
  output logic      [`CR_DATA_W-1:0] rdata_o
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [`CR_DATA_W-1:0] mem_q [DEPTH];

  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      // byte-lane write, untouched lanes keep their value
      if (we_i)
      begin
        for (int i = 0; i < `CR_BE_W; i++)
        begin
          if (be_i[i])
            mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile the core region testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_core_region -f sources.f -Mdir obj_dir

out=$(./obj_dir/Vtb_core_region 2>&1) || true
echo "$out"

echo "$out" | grep -qF '*** TEST PASSED ***'

// File: sources.f
+incdir+rtl
rtl/core_region_pkg.sv
rtl/sp_ram.sv
rtl/ram_mux.sv
rtl/lsu_demux.sv
rtl/ext_bus_bridge.sv
rtl/core_region.sv
tb/tb_core_region.sv

// File: tb/tb_core_region.sv
// testbench for core_region covering slave loading, fetch, load/store and RAM contention
// only words 0..63 of each RAM and of the external memory are exercised
`default_nettype none
`timescale 1ns/1ps

`include "core_region_params.svh"

module tb_core_region;

  import core_region_pkg::*;

  localparam int          WORDS = 64;
  localparam int          LIMIT = 50;
  localparam logic [31:0] SEED  = 32'hc8549e74;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_req;
  logic [`CR_ADDR_W-1:0] instr_addr;
  logic                  instr_gnt;
  logic                  instr_rvalid;
  logic [`CR_DATA_W-1:0] instr_rdata;
  logic                  lsu_req;
  mem_req_t              lsu_req_data;
  logic                  lsu_gnt;
  logic                  lsu_rvalid;
  logic [`CR_DATA_W-1:0] lsu_rdata;
  logic                  slv_valid;
  slv_req_t              slv_req;
  logic                  slv_ready;
  logic                  slv_rsp_valid;
  logic [`CR_DATA_W-1:0] slv_rsp_data;
  logic                  mst_req_valid;
  mem_req_t              mst_req;
  logic                  mst_req_ready;
  logic                  mst_rsp_valid;
  logic [`CR_DATA_W-1:0] mst_rsp_data;
  logic                  mst_rsp_ready;

  // reference model indexed by target then word
  logic [`CR_DATA_W-1:0] ram_model [2][WORDS];
  logic [`CR_DATA_W-1:0] ext_model [WORDS];
  // memory behind the external responder
  logic [`CR_DATA_W-1:0] ext_mem [WORDS];
  logic [31:0]           rng;
  int                    errors;
  int                    bus_errors;
  int                    tests;
  int                    test_start;

  core_region dut0 (
    .clk (clk), .rst_n (rst_n),
    .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
    .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata),
    .lsu_req_i (lsu_req), .lsu_req_data_i (lsu_req_data), .lsu_gnt_o (lsu_gnt),
    .lsu_rvalid_o (lsu_rvalid), .lsu_rdata_o (lsu_rdata),
    .slv_valid_i (slv_valid), .slv_req_i (slv_req), .slv_ready_o (slv_ready),
    .slv_rsp_valid_o (slv_rsp_valid), .slv_rsp_data_o (slv_rsp_data),
    .mst_req_valid_o (mst_req_valid), .mst_req_o (mst_req), .mst_req_ready_i (mst_req_ready),
    .mst_rsp_valid_i (mst_rsp_valid), .mst_rsp_data_i (mst_rsp_data),
    .mst_rsp_ready_o (mst_rsp_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // initial contents keyed on the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h0badf00d;
  endfunction

  // word after a byte-enable write
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
        res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  // random request in a page with word index 0..63 and random low address bits
  function automatic mem_req_t rand_req(input logic [11:0] page);
    mem_req_t    r;
    logic [31:0] x;
    x       = next_rand();
    r.addr  = {page, 12'h000, x[13:8], x[1:0]};
    r.we    = x[2];
    r.be    = x[7:4];
    r.wdata = next_rand();
    return r;
  endfunction

  function automatic logic controls_idle();
    return !(instr_gnt | instr_rvalid | lsu_gnt | lsu_rvalid | slv_ready | slv_rsp_valid |
             mst_req_valid | mst_rsp_ready);
  endfunction

  // 0 slave ready, 1 fetch grant, 2 load/store grant, 3 load/store rvalid
  function automatic logic probe(input int sel);
    case (sel)
      0: return slv_ready;
      1: return instr_gnt;
      2: return lsu_gnt;
      default: return lsu_rvalid;
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("error %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic give_up(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors + bus_errors - test_start);
    test_start = errors + bus_errors;
  endtask

  // n counts the extra cycles spent waiting
  task automatic wait_for(input int sel, input string what, output int n);
    n = 0;
    while (!probe(sel) && n < LIMIT)
    begin
      @(negedge clk);
      #1;
      n++;
    end
    if (!probe(sel))
      give_up(what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // transactions
  ////////////////////////////////////////////////////////////////////////////

  task automatic slave_op(input target_e tgt, input mem_req_t req);
    logic [5:0]  idx;
    logic [31:0] exp;
    int          n;
    idx = req.addr[7:2];
    exp = ram_model[tgt][idx];
    @(negedge clk);
    slv_valid      = 1'b1;
    slv_req.target = tgt;
    slv_req.req    = req;
    #1;
    wait_for(0, "slave ready", n);
    @(negedge clk);
    slv_valid = 1'b0;
    #1;
    if (!slv_rsp_valid)
      report_error("slave response missing one cycle after handshake");
    else if (!req.we && slv_rsp_data !== exp)
      report_error($sformatf("slave read %0d/%0d got %h expected %h",
                             tgt, idx, slv_rsp_data, exp));
    if (req.we)
      ram_model[tgt][idx] = merge_bytes(exp, req.wdata, req.be);
  endtask

  task automatic verify_ram(input target_e tgt);
    mem_req_t r;
    for (int i = 0; i < WORDS; i++)
    begin
      r           = rand_req(12'h000);
      r.addr[7:2] = i[5:0];
      r.we        = 1'b0;
      slave_op(tgt, r);
    end
  endtask

  task automatic fetch_op();
    logic [31:0] x;
    int          n;
    x = next_rand();
    @(negedge clk);
    instr_req  = 1'b1;
    instr_addr = {24'h0, x[7:0]};
    #1;
    wait_for(1, "fetch grant", n);
    @(negedge clk);
    instr_req = 1'b0;
    #1;
    if (!instr_rvalid)
      report_error("fetch rvalid not one cycle after grant");
    else if (instr_rdata !== ram_model[TGT_INSTR][x[7:2]])
      report_error($sformatf("fetch word %0d got %h expected %h",
                             x[7:2], instr_rdata, ram_model[TGT_INSTR][x[7:2]]));
  endtask

  task automatic lsu_op(input logic in_page);
    mem_req_t    r;
    logic [31:0] x;
    logic [11:0] page;
    logic [5:0]  idx;
    logic [31:0] exp;
    int          n;
    x    = next_rand();
    page = in_page ? `CR_LOCAL_PAGE : x[31:20];
    if (!in_page && page == `CR_LOCAL_PAGE)
      page = 12'h800;
    r   = rand_req(page);
    idx = r.addr[7:2];
    exp = in_page ? ram_model[TGT_DATA][idx] : ext_model[idx];
    @(negedge clk);
    lsu_req      = 1'b1;
    lsu_req_data = r;
    #1;
    wait_for(2, "load/store grant", n);
    @(negedge clk);
    // an external request stays up while its response is outstanding
    lsu_req = !in_page;
    #1;
    wait_for(3, "load/store rvalid", n);
    if (in_page && n != 0)
      report_error("local load/store rvalid not one cycle after grant");
    if (!r.we && lsu_rdata !== exp)
      report_error($sformatf("load at %h got %h expected %h", r.addr, lsu_rdata, exp));
    if (r.we && in_page)
      ram_model[TGT_DATA][idx] = merge_bytes(exp, r.wdata, r.be);
    else if (r.we)
      ext_model[idx] = merge_bytes(exp, r.wdata, r.be);
  endtask

  // slave port and load/store port both hammer the data RAM
  task automatic contend(input int cycles);
    mem_req_t    s_r;
    mem_req_t    c_r;
    logic        s_pend;
    logic        c_pend;
    logic        s_read;
    logic        c_read;
    logic [31:0] s_exp;
    logic [31:0] c_exp;
    logic        last_s;
    s_pend = 1'b0;
    c_pend = 1'b0;
    s_read = 1'b0;
    c_read = 1'b0;
    s_exp  = '0;
    c_exp  = '0;
    last_s = 1'b0;
    s_r    = rand_req(12'h000);
    c_r    = rand_req(`CR_LOCAL_PAGE);
    for (int cyc = 0; cyc <= cycles; cyc++)
    begin
      @(negedge clk);
      slv_valid      = (cyc < cycles);
      slv_req.target = TGT_DATA;
      slv_req.req    = s_r;
      lsu_req        = (cyc < cycles);
      lsu_req_data   = c_r;
      #1;
      // responses owed by last cycle's grants
      if (slv_rsp_valid !== s_pend || lsu_rvalid !== c_pend)
        report_error("response valid does not follow its grant by one cycle");
      if (s_pend && s_read && slv_rsp_data !== s_exp)
        report_error($sformatf("slave read got %h expected %h", slv_rsp_data, s_exp));
      if (c_pend && c_read && lsu_rdata !== c_exp)
        report_error($sformatf("core load got %h expected %h", lsu_rdata, c_exp));
      s_pend = slv_ready;
      c_pend = lsu_gnt;
      if (cyc < cycles)
      begin
        if (slv_ready == lsu_gnt)
          report_error("expected exactly one grant while both request");
        else if (cyc > 0 && slv_ready == last_s)
          report_error("grants did not alternate");
        last_s = slv_ready;
      end
      if (slv_ready)
      begin
        s_read = !s_r.we;
        s_exp  = ram_model[TGT_DATA][s_r.addr[7:2]];
        if (s_r.we)
          ram_model[TGT_DATA][s_r.addr[7:2]] = merge_bytes(s_exp, s_r.wdata, s_r.be);
        s_r = rand_req(12'h000);
      end
      if (lsu_gnt)
      begin
        c_read = !c_r.we;
        c_exp  = ram_model[TGT_DATA][c_r.addr[7:2]];
        if (c_r.we)
          ram_model[TGT_DATA][c_r.addr[7:2]] = merge_bytes(c_exp, c_r.wdata, c_r.be);
        c_r = rand_req(`CR_LOCAL_PAGE);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // external memory responder and master port monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic flag_bus_error(input string msg);
    $display("error %0t: %s", $time, msg);
    bus_errors++;
  endtask

  initial
  begin : ext_responder
    logic [31:0] rrng;
    logic        pend;
    int          cnt;
    logic        held;
    mem_req_t    held_req;
    logic [31:0] rsp_word;
    logic [5:0]  idx;
    rrng          = xorshift(~SEED);
    pend          = 1'b0;
    cnt           = 0;
    held          = 1'b0;
    held_req      = '0;
    rsp_word      = '0;
    mst_req_ready = 1'b0;
    mst_rsp_valid = 1'b0;
    mst_rsp_data  = '0;
    for (int i = 0; i < WORDS; i++)
      ext_mem[i] = fill_word(32'h4000_0000 + i * 4);
    forever
    begin
      @(negedge clk);
      rrng          = xorshift(rrng);
      mst_rsp_valid = pend && (cnt == 0);
      mst_rsp_data  = rsp_word;
      if (pend && cnt > 0)
        cnt--;
      mst_req_ready = (rrng[1:0] != 2'b00);
      #1;
      if (mst_req_valid && (mst_req !== lsu_req_data || mst_req.addr[31:20] == `CR_LOCAL_PAGE))
        flag_bus_error("master request differs from the load/store request");
      if (held && (!mst_req_valid || mst_req !== held_req))
        flag_bus_error("master request changed while ready was low");
      if (mst_req_valid && pend)
        flag_bus_error("second master request while one is outstanding");
      held     = mst_req_valid && !mst_req_ready;
      held_req = mst_req;
      if (mst_rsp_valid && mst_rsp_ready)
        pend = 1'b0;
      if (mst_req_valid && mst_req_ready)
      begin
        idx      = mst_req.addr[7:2];
        rsp_word = ext_mem[idx];
        if (mst_req.we)
          ext_mem[idx] = merge_bytes(rsp_word, mst_req.wdata, mst_req.be);
        pend = 1'b1;
        cnt  = int'(rrng[3:2]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : stimulus
    mem_req_t    r;
    logic [31:0] x;
    rng          = SEED;
    errors       = 0;
    bus_errors   = 0;
    tests        = 0;
    test_start   = 0;
    rst_n        = 1'b0;
    instr_req    = 1'b0;
    instr_addr   = '0;
    lsu_req      = 1'b0;
    lsu_req_data = '0;
    slv_valid    = 1'b0;
    slv_req      = '0;
    for (int i = 0; i < WORDS; i++)
      ext_model[i] = fill_word(32'h4000_0000 + i * 4);

    repeat (10)
    begin
      @(negedge clk);
      #1;
      if (!controls_idle())
        report_error("control output high during reset");
    end
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (!controls_idle())
      report_error("control output high right after reset");
    end_test("reset values");

    // full-word load of both RAMs followed by partial writes
    for (int t = 0; t < 2; t++)
    begin
      for (int i = 0; i < WORDS; i++)
      begin
        r.addr  = i * 4;
        r.we    = 1'b1;
        r.be    = 4'hf;
        r.wdata = fill_word(r.addr + t * 32'h0010_0000);
        slave_op(target_e'(t), r);
      end
    end
    repeat (40)
    begin
      x    = next_rand();
      r    = rand_req(12'h000);
      r.we = 1'b1;
      slave_op(target_e'(x[0]), r);
    end
    verify_ram(TGT_INSTR);
    verify_ram(TGT_DATA);
    end_test("slave write and read");

    repeat (64)
      fetch_op();
    end_test("instruction fetch");

    repeat (80)
    begin
      x = next_rand();
      lsu_op(x[0]);
    end
    end_test("load/store local and external");

    contend(40);
    verify_ram(TGT_DATA);
    end_test("slave and core contention");

    $display("tests %0d, errors %0d", tests, errors + bus_errors);
    if (errors + bus_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
